// File: Bender.yml
package:
  name: bin_conv

sources:
  - bin_conv_pkg.sv
  - bin_conv_fetch.sv
  - bin_conv_window.sv
  - bin_conv_writer.sv
  - bin_conv_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_bin_conv.sv

// File: bin_conv_fetch.sv
// fetch controller module with header and row reads, row buffers and column slice generation
module bin_conv_fetch (
	input logic clk,
	input logic reset_b,
	input logic run,
	output logic busy,
	output bin_conv_pkg::addr_t img_addr,
	input bin_conv_pkg::word_t img_data,
	output bin_conv_pkg::addr_t wgt_addr,
	input bin_conv_pkg::word_t wgt_data,
	output bin_conv_pkg::kernel_t kernel,
	output bin_conv_pkg::col_slice_t slice
);

	bin_conv_pkg::fetch_state_t state, state_nxt;

	// image read pointer holds the next address to fetch
	bin_conv_pkg::addr_t rd_ptr;
	// output row address runs across all images
	bin_conv_pkg::addr_t waddr;
	// output row within the current image
	bin_conv_pkg::word_t row_cnt;
	bin_conv_pkg::col_t col_cnt;
	logic [2:0] drain_cnt;

	// image header
	bin_conv_pkg::word_t n_rows;
	bin_conv_pkg::word_t n_cols;
	// three rows under the window with r0 on top
	bin_conv_pkg::word_t r0, r1, r2;

	bin_conv_pkg::col_t col_max;
	logic col_end;
	logic last_row;
	logic end_seen;
	logic drain_done;

	// cols word 16 wraps to 0 and 0-1 gives 15
	assign col_max = n_cols[3:0] - 4'd1;
	assign col_end = (col_cnt == col_max);
	// window bottom sits on the final image row
	assign last_row = (row_cnt + 16'd3 == n_rows);
	assign end_seen = (img_data == bin_conv_pkg::END_MARKER);
	// two pipeline stages plus writer register plus margin
	assign drain_done = (drain_cnt == 3'(bin_conv_pkg::WINDOW_LATENCY + 1));

	// kernel address never changes
	assign wgt_addr = bin_conv_pkg::WEIGHT_DATA_ADDR;
	// data for rd_ptr comes back next cycle
	assign img_addr = rd_ptr;
	assign busy = (state != bin_conv_pkg::idle);

	always_comb begin
		state_nxt = state;
		case (state)
			bin_conv_pkg::idle:
				if (run)
					state_nxt = bin_conv_pkg::weight;
			bin_conv_pkg::weight:
				state_nxt = bin_conv_pkg::rows;
			bin_conv_pkg::rows:
				state_nxt = end_seen ? bin_conv_pkg::drain : bin_conv_pkg::cols;
			bin_conv_pkg::cols:
				state_nxt = bin_conv_pkg::load0;
			bin_conv_pkg::load0:
				state_nxt = bin_conv_pkg::load1;
			bin_conv_pkg::load1:
				state_nxt = bin_conv_pkg::load2;
			bin_conv_pkg::load2:
				state_nxt = bin_conv_pkg::sweep;
			bin_conv_pkg::sweep:
				if (col_end)
					state_nxt = bin_conv_pkg::next_row;
			// last row of an image -> next header already requested
			bin_conv_pkg::next_row:
				state_nxt = last_row ? bin_conv_pkg::rows : bin_conv_pkg::sweep;
			bin_conv_pkg::drain:
				if (drain_done)
					state_nxt = bin_conv_pkg::idle;
			default:
				state_nxt = bin_conv_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= bin_conv_pkg::idle;
			rd_ptr <= '0;
			waddr <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			drain_cnt <= '0;
		end else begin
			state <= state_nxt;
			case (state)
				// stream always starts at image address 0
				bin_conv_pkg::idle: begin
					rd_ptr <= '0;
					waddr <= '0;
				end
				bin_conv_pkg::weight,
				bin_conv_pkg::cols,
				bin_conv_pkg::load0,
				bin_conv_pkg::load1:
					rd_ptr <= rd_ptr + 1'b1;
				bin_conv_pkg::rows: begin
					row_cnt <= '0;
					drain_cnt <= '0;
					if (!end_seen)
						rd_ptr <= rd_ptr + 1'b1;
				end
				bin_conv_pkg::load2:
					col_cnt <= '0;
				bin_conv_pkg::sweep: begin
					col_cnt <= col_end ? '0 : col_cnt + 1'b1;
					// request the next bottom row on the final column
					if (col_end && !last_row)
						rd_ptr <= rd_ptr + 1'b1;
				end
				bin_conv_pkg::next_row: begin
					waddr <= waddr + 1'b1;
					if (last_row) begin
						// step past the next image header now being read
						rd_ptr <= rd_ptr + 1'b1;
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end
				bin_conv_pkg::drain:
					drain_cnt <= drain_cnt + 1'b1;
				default: ;
			endcase
		end
	end

	// header, kernel and row buffers
	always_ff @(posedge clk) begin
		case (state)
			bin_conv_pkg::weight:
				kernel <= wgt_data[bin_conv_pkg::KERNEL_BITS-1:0];
			bin_conv_pkg::rows:
				n_rows <= img_data;
			bin_conv_pkg::cols:
				n_cols <= img_data;
			bin_conv_pkg::load0:
				r0 <= img_data;
			bin_conv_pkg::load1:
				r1 <= img_data;
			bin_conv_pkg::load2:
				r2 <= img_data;
			// shift rows up and take the new bottom row from the sweep read
			bin_conv_pkg::next_row:
				if (!last_row) begin
					r0 <= r1;
					r1 <= r2;
					r2 <= img_data;
				end
			default: ;
		endcase
	end

	// one column per sweep cycle
	always_comb begin
		slice.valid = (state == bin_conv_pkg::sweep);
		slice.col = col_cnt;
		slice.pix = {r2[col_cnt], r1[col_cnt], r0[col_cnt]};
		slice.last = slice.valid && col_end;
		slice.waddr = waddr;
	end

	// sweep never runs past the row width from the header
	a_col_in_range: assert property (@(posedge clk) disable iff (!reset_b)
		slice.valid |-> ({12'd0, slice.col} < n_cols));

endmodule

// File: bin_conv_pkg.sv
// package: widths, memory addresses, end marker, fetch states, slice and result structs
package bin_conv_pkg;

	// memory geometry
	localparam int ADDR_W = 12;
	localparam int WORD_W = 16;
	// widest image row, one bit per column
	localparam int MAX_COLS = 16;
	// 3x3 kernel
	localparam int KERNEL_BITS = 9;

	// kernel word in weight memory, dims word at 0 never read
	localparam logic [ADDR_W-1:0] WEIGHT_DATA_ADDR = 12'h001;
	// row count that stops the image stream
	localparam logic [WORD_W-1:0] END_MARKER = 16'h00FF;
	// 5 of 9 negative products flips the output bit to 0
	localparam int MAJORITY = 5;
	// slice in to result out
	localparam int WINDOW_LATENCY = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [$clog2(MAX_COLS)-1:0] col_t;
	// bit 3*i+j -> window row i, window column j
	typedef logic [KERNEL_BITS-1:0] kernel_t;

	typedef enum logic [3:0] {
		idle, weight, rows, cols, load0, load1, load2, sweep, next_row, drain
	} fetch_state_t;

	// one image column across the three buffered rows
	typedef struct packed {
		logic valid;
		col_t col;
		logic [2:0] pix;
		logic last;
		addr_t waddr;
	} col_slice_t;

	// one output bit, value is the majority result
	typedef struct packed {
		logic valid;
		col_t col;
		logic value;
		logic last;
		addr_t waddr;
	} win_result_t;

endpackage

// File: bin_conv_top.f
bin_conv_pkg.sv
bin_conv_fetch.sv
bin_conv_window.sv
bin_conv_writer.sv
bin_conv_top.sv
tb_clk_gen.sv
tb_bin_conv.sv

// File: bin_conv_top.sv
// module bin_conv_top: fetch, window and writer wired to the memory ports
module bin_conv_top (
	input logic clk,
	input logic reset_b,
	// start pulse, sampled while idle
	input logic run,
	output logic busy,
	// image memory read port
	output bin_conv_pkg::addr_t img_addr,
	input bin_conv_pkg::word_t img_data,
	// weight memory read port
	output bin_conv_pkg::addr_t wgt_addr,
	input bin_conv_pkg::word_t wgt_data,
	// output memory write port
	output logic write_en,
	output bin_conv_pkg::addr_t write_addr,
	output bin_conv_pkg::word_t write_data
);

	// kernel held by fetch for the whole run
	bin_conv_pkg::kernel_t kernel;
	// fetch -> window
	bin_conv_pkg::col_slice_t slice;
	// window -> writer
	bin_conv_pkg::win_result_t result;

	// headers, row buffers, column slices
	bin_conv_fetch u_fetch (
		.clk(clk),
		.reset_b(reset_b),
		.run(run),
		.busy(busy),
		.img_addr(img_addr),
		.img_data(img_data),
		.wgt_addr(wgt_addr),
		.wgt_data(wgt_data),
		.kernel(kernel),
		.slice(slice)
	);

	// products and majority, two cycles
	bin_conv_window u_window (
		.clk(clk),
		.reset_b(reset_b),
		.kernel(kernel),
		.slice(slice),
		.result(result)
	);

	// one output word per row
	bin_conv_writer u_writer (
		.clk(clk),
		.reset_b(reset_b),
		.result(result),
		.write_en(write_en),
		.write_addr(write_addr),
		.write_data(write_data)
	);

endmodule

// File: bin_conv_window.sv
// window pipeline module with 3x3 shift register, xnor products and majority vote
module bin_conv_window (
	input logic clk,
	input logic reset_b,
	input bin_conv_pkg::kernel_t kernel,
	input bin_conv_pkg::col_slice_t slice,
	output bin_conv_pkg::win_result_t result
);

	// the two columns left of the incoming slice
	logic [2:0] col_m2, col_m1;
	// bit j of window row i is window column j
	logic [2:0][2:0] win;
	// pixel differs from weight -> negative product
	logic [2:0][2:0] neg;
	logic [2:0][1:0] row_neg;

	// stage one
	logic [2:0][1:0] s1_neg;
	logic s1_valid;
	logic s1_last;
	bin_conv_pkg::col_t s1_col;
	bin_conv_pkg::addr_t s1_waddr;

	// stage two
	logic [3:0] neg_sum;

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			win[i] = {slice.pix[i], col_m1[i], col_m2[i]};
			neg[i] = win[i] ^ kernel[3*i +: 3];
			row_neg[i] = 2'(neg[i][0]) + 2'(neg[i][1]) + 2'(neg[i][2]);
		end
	end

	// shift only on real columns
	always_ff @(posedge clk) begin
		if (slice.valid) begin
			col_m2 <= col_m1;
			col_m1 <= slice.pix;
		end
		s1_neg <= row_neg;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			s1_col <= '0;
			s1_waddr <= '0;
		end else begin
			// columns 0 and 1 only fill the window
			s1_valid <= slice.valid && (slice.col >= 4'd2);
			s1_last <= slice.last;
			s1_col <= slice.col - 4'd2;
			s1_waddr <= slice.waddr;
		end
	end

	assign neg_sum = 4'(s1_neg[0]) + 4'(s1_neg[1]) + 4'(s1_neg[2]);

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			result <= '0;
		end else begin
			result.valid <= s1_valid;
			result.col <= s1_col;
			// positive unless negatives hold the majority
			result.value <= (neg_sum < 4'(bin_conv_pkg::MAJORITY));
			result.last <= s1_last;
			result.waddr <= s1_waddr;
		end
	end

	a_result_from_slice: assert property (@(posedge clk) disable iff (!reset_b)
		result.valid |-> $past(slice.valid, bin_conv_pkg::WINDOW_LATENCY));

endmodule

// File: bin_conv_writer.sv
// module bin_conv_writer: row word assembly and output memory write strobe
module bin_conv_writer (
	input logic clk,
	input logic reset_b,
	input bin_conv_pkg::win_result_t result,
	output logic write_en,
	output bin_conv_pkg::addr_t write_addr,
	output bin_conv_pkg::word_t write_data
);

	// bits of the row collected so far
	bin_conv_pkg::word_t row_word;
	// row word with the current result merged in
	bin_conv_pkg::word_t row_word_nxt;

	always_comb begin
		row_word_nxt = row_word;
		// result column maps straight to word bit
		if (result.valid)
			row_word_nxt[result.col] = result.value;
	end

	// control side, strobe and accumulator
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			write_en <= 1'b0;
			row_word <= '0;
		end else begin
			// single cycle pulse per finished row
			write_en <= result.last;
			// unused high columns stay 0 in every row
			if (result.last)
				row_word <= '0;
			else
				row_word <= row_word_nxt;
		end
	end

	// write port payload, held until the next row completes
	always_ff @(posedge clk) begin
		if (result.last) begin
			write_addr <= result.waddr;
			write_data <= row_word_nxt;
		end
	end

	// rows are at least three slices apart, so strobes never touch
	a_single_strobe: assert property (@(posedge clk) disable iff (!reset_b)
		write_en |=> !write_en);

endmodule

// File: tb_bin_conv.sv
// testbench top with memory models, golden model, compare tasks, directed tests and report
module tb_bin_conv;

	logic clk;
	logic reset_b;
	logic run;
	logic busy;
	bin_conv_pkg::addr_t img_addr;
	bin_conv_pkg::word_t img_data;
	bin_conv_pkg::addr_t wgt_addr;
	bin_conv_pkg::word_t wgt_data;
	logic write_en;
	bin_conv_pkg::addr_t write_addr;
	bin_conv_pkg::word_t write_data;

	// image and weight memories
	bin_conv_pkg::word_t img_mem [0:4095];
	bin_conv_pkg::word_t wgt_mem [0:4095];
	// rows of the image under construction
	bin_conv_pkg::word_t img_buf [0:15];
	// golden words and recorded writes
	bin_conv_pkg::word_t exp_q [$];
	bin_conv_pkg::word_t got_data [$];
	bin_conv_pkg::addr_t got_addr [$];
	// busy level seen with each write
	logic got_busy [$];

	bin_conv_pkg::kernel_t kern;
	bin_conv_pkg::addr_t load_ptr;
	int seed;
	int errors;
	int tests_run;
	int tests_failed;
	// set once a wait times out and the DUT state is no longer known
	logic hung;

	tb_clk_gen u_clk_gen (.clk(clk), .reset_b(reset_b));

	bin_conv_top u_bin_conv_top (
		.clk(clk),
		.reset_b(reset_b),
		.run(run),
		.busy(busy),
		.img_addr(img_addr),
		.img_data(img_data),
		.wgt_addr(wgt_addr),
		.wgt_data(wgt_data),
		.write_en(write_en),
		.write_addr(write_addr),
		.write_data(write_data)
	);

	// memories with one cycle read latency and the output memory as a write log
	always @(posedge clk) begin
		img_data <= img_mem[img_addr];
		wgt_data <= wgt_mem[wgt_addr];
		if (write_en) begin
			got_addr.push_back(write_addr);
			got_data.push_back(write_data);
			got_busy.push_back(busy);
		end
	end

	// 1 unless five or more of the nine pixel/weight pairs differ
	function automatic logic golden_bit(input bin_conv_pkg::kernel_t k,
		input bin_conv_pkg::word_t top, input bin_conv_pkg::word_t mid,
		input bin_conv_pkg::word_t bot, input int col);
		logic [2:0][15:0] r;
		int negs;
		r = {bot, mid, top};
		negs = 0;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 3; j++)
				if (r[i][col + j] != k[3 * i + j])
					negs++;
		return negs < 5;
	endfunction

	task automatic check_word(input string name, input bin_conv_pkg::word_t exp,
		input bin_conv_pkg::word_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input bin_conv_pkg::addr_t exp,
		input bin_conv_pkg::addr_t act);
		if (act !== exp) begin
			$display("mismatch %s addr: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// fill both memories, put the kernel at weight address 1 and empty the queues
	task automatic clear_stream(input bin_conv_pkg::kernel_t k);
		for (int a = 0; a < 4096; a++) begin
			img_mem[a] = 16'hC000 | 16'(a);
			wgt_mem[a] = 16'h3000 | 16'(a);
		end
		// dims word is never read for a fixed 3x3 kernel
		wgt_mem[0] = 16'h0303;
		wgt_mem[1] = {7'd0, k};
		kern = k;
		load_ptr = '0;
		exp_q.delete();
		got_addr.delete();
		got_data.delete();
		got_busy.delete();
	endtask

	// header and img_buf rows go into memory and golden words onto exp_q
	task automatic add_image(input int n_rows, input int n_cols);
		bin_conv_pkg::word_t w;
		img_mem[load_ptr] = 16'(n_rows);
		img_mem[load_ptr + 1] = 16'(n_cols);
		load_ptr = load_ptr + 2;
		for (int r = 0; r < n_rows; r++) begin
			img_mem[load_ptr] = img_buf[r];
			load_ptr = load_ptr + 1;
		end
		for (int r = 0; r + 2 < n_rows; r++) begin
			w = '0;
			for (int c = 0; c + 2 < n_cols; c++)
				w[c] = golden_bit(kern, img_buf[r], img_buf[r + 1], img_buf[r + 2], c);
			exp_q.push_back(w);
		end
	endtask

	// 3x3 image equal to the kernel except where mask is set
	task automatic kernel_image(input bin_conv_pkg::kernel_t k,
		input bin_conv_pkg::kernel_t mask);
		for (int i = 0; i < 3; i++)
			img_buf[i] = 16'((k ^ mask) >> (3 * i)) & 16'h0007;
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (reset_b !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (reset_b !== 1'b1) begin
			$display("error: reset was never released");
			errors++;
			hung = 1'b1;
		end
		@(posedge clk);
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (busy !== level) begin
			$display("error: %s, busy still %b after %0d cycles", what, busy, limit);
			errors++;
			hung = 1'b1;
		end
	endtask

	// end marker, run pulse and wait for idle before comparing the write log
	task automatic run_stream(input string name);
		if (hung)
			return;
		img_mem[load_ptr] = bin_conv_pkg::END_MARKER;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		wait_busy(1'b1, 4, {name, ": busy did not rise after run"});
		if (!hung)
			wait_busy(1'b0, 5000, {name, ": busy did not fall"});
		if (hung)
			return;
		@(posedge clk);
		if (got_data.size() != exp_q.size()) begin
			$display("error: %s wrote %0d words, expected %0d", name, got_data.size(),
				exp_q.size());
			errors++;
		end
		for (int i = 0; i < got_data.size() && i < exp_q.size(); i++) begin
			check_addr(name, 12'(i), got_addr[i]);
			check_word(name, exp_q[i], got_data[i]);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before && !hung) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		check_bit("reset_state busy", 1'b0, busy);
		check_bit("reset_state write_en", 1'b0, write_en);
		end_test("reset_state", e);
	endtask

	task automatic test_all_ones();
		int e;
		e = errors;
		clear_stream(9'h1FF);
		for (int r = 0; r < 5; r++)
			img_buf[r] = 16'h00FF;
		add_image(5, 8);
		run_stream("all_ones_kernel");
		// 8 columns give 6 output bits that are all positive
		for (int i = 0; i < got_data.size(); i++)
			check_word("all_ones_kernel", 16'h003F, got_data[i]);
		end_test("all_ones_kernel", e);
	endtask

	task automatic test_mixed();
		int e;
		e = errors;
		// checkerboard kernel
		clear_stream(9'h155);
		for (int r = 0; r < 6; r++)
			img_buf[r] = 16'($random(seed));
		add_image(6, 16);
		run_stream("mixed_kernel");
		end_test("mixed_kernel", e);
	endtask

	task automatic test_multi();
		int e;
		e = errors;
		clear_stream(9'h0F3);
		for (int r = 0; r < 4; r++)
			img_buf[r] = 16'($random(seed));
		add_image(4, 12);
		for (int r = 0; r < 3; r++)
			img_buf[r] = 16'($random(seed));
		add_image(3, 9);
		run_stream("multi_image");
		// busy still high at the last write and low only afterwards
		if (got_busy.size() > 0)
			check_bit("multi_image busy at last write", 1'b1,
				got_busy[got_busy.size() - 1]);
		end_test("multi_image", e);
	endtask

	task automatic test_immediate_end();
		int e;
		e = errors;
		// end marker at address 0 with no image
		clear_stream(9'h1FF);
		run_stream("immediate_end");
		end_test("immediate_end", e);
	endtask

	task automatic test_majority();
		int e;
		e = errors;
		clear_stream(9'h0B5);
		// four differing pixels stay positive
		kernel_image(9'h0B5, 9'h055);
		add_image(3, 3);
		// five differing pixels turn negative
		kernel_image(9'h0B5, 9'h155);
		add_image(3, 3);
		run_stream("majority_threshold");
		if (got_data.size() == 2) begin
			check_word("majority_threshold four", 16'h0001, got_data[0]);
			check_word("majority_threshold five", 16'h0000, got_data[1]);
		end
		end_test("majority_threshold", e);
	endtask

	initial begin
		run = 1'b0;
		img_data = '0;
		wgt_data = '0;
		seed = 32'h3949_6fc0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		hung = 1'b0;
		clear_stream('0);
		wait_reset();
		test_reset_state();
		test_all_ones();
		test_mixed();
		test_multi();
		test_immediate_end();
		test_majority();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: tb_clk_gen.sv
// module tb_clk_gen: testbench clock and power-on reset
module tb_clk_gen (
	output logic clk,
	output logic reset_b
);

	// period of 40 time units
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset low for the first 5 rising edges
	initial begin
		reset_b = 1'b0;
		repeat (5) @(posedge clk);
		reset_b <= 1'b1;
	end

endmodule
